// File: Makefile
VERILATOR ?= verilator
TOP ?= rv_core_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Test completed successfully
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := include/rv_cfg.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+include
source/rv_core_pkg.sv
source/rv_isa_pkg.sv
source/key_mux.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_exu.sv
source/rv_dmem.sv
source/rv_core.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

// File: include/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// core sizing
`define RV_XLEN 32
`define RV_NREGS 32

// data memory depth in words
`define RV_DMEM_WORDS 256

`define RV_RESET_PC 32'h0000_0000

`endif

// File: source/key_mux.sv
`timescale 1ns/1ps

module key_mux #(
	parameter int NR_KEY = 2,
	parameter int KEY_LEN = 7,
	parameter type out_t = rv_core_pkg::word_t
) (
	input logic [KEY_LEN-1:0] key,
	input out_t default_out,
	input logic [KEY_LEN-1:0] lut_keys [NR_KEY],
	input out_t lut_vals [NR_KEY],
	output out_t out
);

	out_t acc;
	logic hit;

	// keys are unique so at most one entry contributes
	always_comb begin
		acc = '0;
		hit = 1'b0;
		for (int i = 0; i < NR_KEY; i++) begin
			if (key == lut_keys[i]) begin
				acc = acc | lut_vals[i];
				hit = 1'b1;
			end
		end
	end

	assign out = hit ? acc : default_out; // fall back when nothing matched

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core (
	input logic clk,
	input logic rst_n,
	output rv_core_pkg::word_t instr_addr,
	input rv_core_pkg::word_t instr,
	output logic wb_en,
	output rv_core_pkg::reg_idx_t wb_rd,
	output rv_core_pkg::word_t wb_data,
	output logic mem_wen,
	output rv_core_pkg::word_t mem_addr,
	output rv_core_pkg::word_t mem_wdata,
	output rv_core_pkg::byte_mask_t mem_wmask
);

	rv_core_pkg::word_t pc;
	rv_core_pkg::opcode_t opcode;
	rv_core_pkg::reg_idx_t rd;
	rv_core_pkg::reg_idx_t rs1;
	rv_core_pkg::reg_idx_t rs2;
	rv_core_pkg::funct3_t funct3;
	rv_core_pkg::funct7_t funct7;
	rv_core_pkg::word_t imm;
	rv_core_pkg::word_t src1;
	rv_core_pkg::word_t src2;
	rv_core_pkg::word_t mem_rdata;
	rv_core_pkg::word_t jump_target;
	logic jump_en;
	logic exu_wb_en;
	logic exu_mem_wen;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `RV_RESET_PC;
		end else begin
			pc <= jump_en ? jump_target : pc + 32'd4;
		end
	end

	assign instr_addr = pc;
	assign wb_rd = rd;
	assign wb_en = exu_wb_en && rst_n; // no state changes in reset
	assign mem_wen = exu_mem_wen && rst_n;

	rv_decode u_decode (
		.instr(instr),
		.opcode(opcode),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.funct3(funct3),
		.funct7(funct7),
		.imm(imm)
	);

	rv_regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.rs1(rs1),
		.rs2(rs2),
		.rdata1(src1),
		.rdata2(src2),
		.wen(wb_en),
		.waddr(rd),
		.wdata(wb_data)
	);

	rv_exu u_exu (
		.opcode(opcode),
		.funct3(funct3),
		.funct7(funct7),
		.rd(rd),
		.src1(src1),
		.src2(src2),
		.imm(imm),
		.pc(pc),
		.mem_rdata(mem_rdata),
		.val(wb_data),
		.wb_en(exu_wb_en),
		.jump_en(jump_en),
		.jump_target(jump_target),
		.mem_wen(exu_mem_wen),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wmask(mem_wmask)
	);

	rv_dmem u_dmem (
		.clk(clk),
		.rst_n(rst_n),
		.wen(mem_wen),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.wmask(mem_wmask),
		.rdata(mem_rdata)
	);

endmodule

// File: source/rv_core_pkg.sv
`include "rv_cfg.svh"

package rv_core_pkg;

	typedef logic [`RV_XLEN-1:0] word_t; // data or address word
	typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
	typedef logic [`RV_XLEN/8-1:0] byte_mask_t; // one bit per store lane

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

endpackage

// File: source/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
	input rv_core_pkg::word_t instr,
	output rv_core_pkg::opcode_t opcode,
	output rv_core_pkg::reg_idx_t rd,
	output rv_core_pkg::reg_idx_t rs1,
	output rv_core_pkg::reg_idx_t rs2,
	output rv_core_pkg::funct3_t funct3,
	output rv_core_pkg::funct7_t funct7,
	output rv_core_pkg::word_t imm
);

	rv_core_pkg::word_t imm_i;
	rv_core_pkg::word_t imm_s;
	rv_core_pkg::word_t imm_u;
	rv_core_pkg::word_t imm_j;

	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_u = {instr[31:12], 12'b0};
	// j-type bits are scrambled in the encoding
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		case (opcode)
			rv_isa_pkg::OP_JALR,
			rv_isa_pkg::OP_LOAD,
			rv_isa_pkg::OP_IMM: begin
				imm = imm_i;
			end
			rv_isa_pkg::OP_STORE: begin
				imm = imm_s;
			end
			rv_isa_pkg::OP_LUI,
			rv_isa_pkg::OP_AUIPC: begin
				imm = imm_u;
			end
			rv_isa_pkg::OP_JAL: begin
				imm = imm_j;
			end
			default: begin
				imm = '0; // r-type has no immediate
			end
		endcase
	end

endmodule

// File: source/rv_dmem.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_dmem (
	input logic clk,
	input logic rst_n,
	input logic wen,
	input rv_core_pkg::word_t addr,
	input rv_core_pkg::word_t wdata,
	input rv_core_pkg::byte_mask_t wmask,
	output rv_core_pkg::word_t rdata
);

	localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

	rv_core_pkg::word_t mem [`RV_DMEM_WORDS];

	logic [IDX_W-1:0] idx;
	logic [1:0] offs;
	rv_core_pkg::word_t wdata_sh;
	rv_core_pkg::byte_mask_t wmask_sh;

	assign idx = addr[IDX_W+1:2]; // word index
	assign offs = addr[1:0];

	// move sub-word store data onto its byte lanes
	assign wdata_sh = wdata << {offs, 3'b000};
	assign wmask_sh = wmask << offs;

	always_ff @(posedge clk) begin
		if (rst_n && wen) begin
			for (int b = 0; b < `RV_XLEN/8; b++) begin
				if (wmask_sh[b]) begin
					mem[idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
				end
			end
		end
	end

	assign rdata = mem[idx];

endmodule

// File: source/rv_exu.sv
`timescale 1ns/1ps

module rv_exu (
	input rv_core_pkg::opcode_t opcode,
	input rv_core_pkg::funct3_t funct3,
	input rv_core_pkg::funct7_t funct7,
	input rv_core_pkg::reg_idx_t rd,
	input rv_core_pkg::word_t src1,
	input rv_core_pkg::word_t src2,
	input rv_core_pkg::word_t imm,
	input rv_core_pkg::word_t pc,
	input rv_core_pkg::word_t mem_rdata,
	output rv_core_pkg::word_t val,
	output logic wb_en,
	output logic jump_en,
	output rv_core_pkg::word_t jump_target,
	output logic mem_wen,
	output rv_core_pkg::word_t mem_addr,
	output rv_core_pkg::word_t mem_wdata,
	output rv_core_pkg::byte_mask_t mem_wmask
);

	logic [6:0] op_keys [3];
	rv_core_pkg::word_t op_vals [3];
	logic [9:0] f3_keys [4];
	rv_core_pkg::word_t f3_vals [4];
	logic [9:0] mask_keys [3];
	rv_core_pkg::byte_mask_t mask_vals [3];

	rv_core_pkg::word_t val_op;
	rv_core_pkg::word_t val_f3;
	rv_core_pkg::word_t add_res;
	rv_core_pkg::word_t addr_sum;
	logic is_jal;
	logic is_jalr;
	logic writes_rd;

	assign addr_sum = src1 + imm; // shared by loads, stores, addi and jalr
	assign add_res = (funct7 == rv_isa_pkg::F7_ADD) ? src1 + src2 : '0;

	assign op_keys = '{rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_JAL};
	assign op_vals = '{imm, pc + imm, pc + 32'd4};

	assign f3_keys = '{
		{rv_isa_pkg::F3_LW, rv_isa_pkg::OP_LOAD},
		{rv_isa_pkg::F3_ADD, rv_isa_pkg::OP_IMM},
		{rv_isa_pkg::F3_JALR, rv_isa_pkg::OP_JALR},
		{rv_isa_pkg::F3_ADD, rv_isa_pkg::OP_REG}
	};
	assign f3_vals = '{mem_rdata, addr_sum, pc + 32'd4, add_res};

	assign mask_keys = '{
		{rv_isa_pkg::F3_SB, rv_isa_pkg::OP_STORE},
		{rv_isa_pkg::F3_SH, rv_isa_pkg::OP_STORE},
		{rv_isa_pkg::F3_SW, rv_isa_pkg::OP_STORE}
	};
	assign mask_vals = '{4'h1, 4'h3, 4'hf};

	key_mux #(.NR_KEY(3), .KEY_LEN(7), .out_t(rv_core_pkg::word_t)) u_val_op (
		.key(opcode),
		.default_out('0),
		.lut_keys(op_keys),
		.lut_vals(op_vals),
		.out(val_op)
	);

	key_mux #(.NR_KEY(4), .KEY_LEN(10), .out_t(rv_core_pkg::word_t)) u_val_f3 (
		.key({funct3, opcode}),
		.default_out('0),
		.lut_keys(f3_keys),
		.lut_vals(f3_vals),
		.out(val_f3)
	);

	key_mux #(.NR_KEY(3), .KEY_LEN(10), .out_t(rv_core_pkg::byte_mask_t)) u_wmask (
		.key({funct3, opcode}),
		.default_out('0),
		.lut_keys(mask_keys),
		.lut_vals(mask_vals),
		.out(mem_wmask)
	);

	assign val = val_op | val_f3;

	// which encodings produce a register result
	always_comb begin
		case (opcode)
			rv_isa_pkg::OP_LUI,
			rv_isa_pkg::OP_AUIPC,
			rv_isa_pkg::OP_JAL: writes_rd = 1'b1;
			rv_isa_pkg::OP_JALR: writes_rd = (funct3 == rv_isa_pkg::F3_JALR);
			rv_isa_pkg::OP_LOAD: writes_rd = (funct3 == rv_isa_pkg::F3_LW);
			rv_isa_pkg::OP_IMM: writes_rd = (funct3 == rv_isa_pkg::F3_ADD);
			rv_isa_pkg::OP_REG: begin
				writes_rd = (funct3 == rv_isa_pkg::F3_ADD) && (funct7 == rv_isa_pkg::F7_ADD);
			end
			default: writes_rd = 1'b0;
		endcase
	end

	assign wb_en = writes_rd && (rd != '0);

	assign is_jal = (opcode == rv_isa_pkg::OP_JAL);
	assign is_jalr = (opcode == rv_isa_pkg::OP_JALR) && (funct3 == rv_isa_pkg::F3_JALR);
	assign jump_en = is_jal || is_jalr;
	assign jump_target = is_jal ? pc + imm : {addr_sum[31:1], 1'b0};

	assign mem_wen = (opcode == rv_isa_pkg::OP_STORE) && ((funct3 == rv_isa_pkg::F3_SB) ||
		(funct3 == rv_isa_pkg::F3_SH) || (funct3 == rv_isa_pkg::F3_SW)); // sb, sh and sw only
	assign mem_addr = addr_sum;
	assign mem_wdata = src2; // lane shift happens in dmem

endmodule

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes
	localparam rv_core_pkg::opcode_t OP_LUI = 7'b0110111;
	localparam rv_core_pkg::opcode_t OP_AUIPC = 7'b0010111;
	localparam rv_core_pkg::opcode_t OP_JAL = 7'b1101111;
	localparam rv_core_pkg::opcode_t OP_JALR = 7'b1100111;
	localparam rv_core_pkg::opcode_t OP_LOAD = 7'b0000011;
	localparam rv_core_pkg::opcode_t OP_STORE = 7'b0100011;
	localparam rv_core_pkg::opcode_t OP_IMM = 7'b0010011;
	localparam rv_core_pkg::opcode_t OP_REG = 7'b0110011;

	// funct3 selections
	localparam rv_core_pkg::funct3_t F3_LW = 3'b010;
	localparam rv_core_pkg::funct3_t F3_SB = 3'b000;
	localparam rv_core_pkg::funct3_t F3_SH = 3'b001;
	localparam rv_core_pkg::funct3_t F3_SW = 3'b010;
	localparam rv_core_pkg::funct3_t F3_ADD = 3'b000; // addi and add
	localparam rv_core_pkg::funct3_t F3_JALR = 3'b000;

	localparam rv_core_pkg::funct7_t F7_ADD = 7'b0000000;

endpackage

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_regfile (
	input logic clk,
	input logic rst_n,
	input rv_core_pkg::reg_idx_t rs1,
	input rv_core_pkg::reg_idx_t rs2,
	output rv_core_pkg::word_t rdata1,
	output rv_core_pkg::word_t rdata2,
	input logic wen,
	input rv_core_pkg::reg_idx_t waddr,
	input rv_core_pkg::word_t wdata
);

	rv_core_pkg::word_t regs [`RV_NREGS];

	// x0 slot is never written
	always_ff @(posedge clk) begin
		if (rst_n && wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: tb/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
	input logic clk,
	input logic rst_n,
	input logic wb_en,
	input rv_core_pkg::reg_idx_t wb_rd,
	input logic mem_wen,
	input rv_core_pkg::byte_mask_t mem_wmask
);

	// no architectural state may change under reset
	reset_quiet: assert property (@(posedge clk) !rst_n |-> (!wb_en && !mem_wen))
		else $error("write enable high during reset");

	no_x0_write: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> (wb_rd != '0))
		else $error("writeback targets x0");

	store_mask: assert property (@(posedge clk) disable iff (!rst_n)
		mem_wen |-> (mem_wmask != '0))
		else $error("store enabled with an empty byte mask");

endmodule

bind rv_core rv_core_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.wb_en(wb_en),
	.wb_rd(wb_rd),
	.mem_wen(mem_wen),
	.mem_wmask(mem_wmask)
);

// File: tb/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_cfg.svh"

module rv_core_tb;

	localparam int PROG_WORDS = 256;
	localparam int PREFIX_END = 48; // register and memory init
	localparam int RAND_START = 59;
	localparam int RUN_CYCLES = 3000;
	localparam int TIMEOUT_CYCLES = 3500;
	localparam int JUMP_BASE = 64;
	localparam rv_core_pkg::word_t NOP = 32'h0000_0013;
	localparam rv_core_pkg::reg_idx_t MEM_REG = 5'd30; // memory base never overwritten
	localparam rv_core_pkg::reg_idx_t JUMP_REG = 5'd31; // jalr base

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	rv_core_pkg::word_t instr = '0;
	rv_core_pkg::word_t instr_addr;
	logic wb_en;
	rv_core_pkg::reg_idx_t wb_rd;
	rv_core_pkg::word_t wb_data;
	logic mem_wen;
	rv_core_pkg::word_t mem_addr;
	rv_core_pkg::word_t mem_wdata;
	rv_core_pkg::byte_mask_t mem_wmask;

	rv_core_pkg::word_t prog [PROG_WORDS];
	integer seed;
	int retired = 0;

	// ISA model state
	rv_core_pkg::word_t m_regs [`RV_NREGS];
	rv_core_pkg::word_t m_mem [`RV_DMEM_WORDS];
	rv_core_pkg::word_t m_pc;

	logic exp_wb_en;
	rv_core_pkg::reg_idx_t exp_rd;
	rv_core_pkg::word_t exp_wb_data;
	logic exp_mem_wen;
	rv_core_pkg::word_t exp_mem_addr;
	rv_core_pkg::word_t exp_mem_wdata;
	rv_core_pkg::byte_mask_t exp_mem_wmask;

	rv_core u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.instr_addr(instr_addr),
		.instr(instr),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.mem_wen(mem_wen),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_wmask(mem_wmask)
	);

	initial begin
		forever #10 clk = ~clk;
	end

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic rv_core_pkg::reg_idx_t rand_reg(input int unsigned n);
		return rv_core_pkg::reg_idx_t'(rand_below(n));
	endfunction

	function automatic rv_core_pkg::word_t enc_i(input logic [11:0] imm,
			input rv_core_pkg::reg_idx_t rs1, input rv_core_pkg::funct3_t f3,
			input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::opcode_t op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_core_pkg::word_t enc_s(input logic [11:0] imm,
			input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1,
			input rv_core_pkg::funct3_t f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OP_STORE};
	endfunction

	function automatic rv_core_pkg::word_t enc_r(input rv_core_pkg::funct7_t f7,
			input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1,
			input rv_core_pkg::reg_idx_t rd);
		return {f7, rs2, rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_REG};
	endfunction

	function automatic rv_core_pkg::word_t enc_u(input logic [19:0] imm,
			input rv_core_pkg::reg_idx_t rd, input rv_core_pkg::opcode_t op);
		return {imm, rd, op};
	endfunction

	function automatic rv_core_pkg::word_t enc_j(input logic [20:0] off,
			input rv_core_pkg::reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
	endfunction

	task automatic build_program();
		rv_core_pkg::word_t rw;
		rv_core_pkg::reg_idx_t rd;
		rv_core_pkg::reg_idx_t rs1;
		rv_core_pkg::reg_idx_t rs2;
		int unsigned tgt;
		int unsigned pick;
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = NOP;
		end
		for (int r = 1; r < 30; r++) begin
			rw = rv_core_pkg::word_t'($random(seed));
			prog[r - 1] = enc_u(rw[31:12], rv_core_pkg::reg_idx_t'(r), rv_isa_pkg::OP_LUI);
		end
		prog[29] = enc_u(20'h0, MEM_REG, rv_isa_pkg::OP_LUI);
		prog[30] = enc_i(12'h200, MEM_REG, rv_isa_pkg::F3_ADD, MEM_REG, rv_isa_pkg::OP_IMM);
		prog[31] = enc_i(12'(JUMP_BASE), 5'd0, rv_isa_pkg::F3_ADD, JUMP_REG, rv_isa_pkg::OP_IMM);
		for (int k = 0; k < 16; k++) begin
			prog[32 + k] = enc_s(12'(4 * k), rv_core_pkg::reg_idx_t'(k + 1), MEM_REG,
				rv_isa_pkg::F3_SW);
		end
		// sub-word stores then a load of the merged word
		prog[48] = enc_s(12'd1, 5'd1, MEM_REG, rv_isa_pkg::F3_SB);
		prog[49] = enc_s(12'd2, 5'd2, MEM_REG, rv_isa_pkg::F3_SH);
		prog[50] = enc_i(12'd0, MEM_REG, rv_isa_pkg::F3_LW, 5'd3, rv_isa_pkg::OP_LOAD);
		prog[51] = enc_r(rv_isa_pkg::F7_ADD, 5'd2, 5'd1, 5'd0); // x0 stays zero
		prog[52] = enc_i(12'hfff, 5'd0, rv_isa_pkg::F3_ADD, 5'd4, rv_isa_pkg::OP_IMM);
		prog[53] = enc_r(7'b0100000, 5'd2, 5'd1, 5'd6); // sub is not supported
		prog[54] = enc_j(21'd8, 5'd5);
		prog[56] = enc_i(12'(RAND_START * 4 - JUMP_BASE + 1), JUMP_REG, rv_isa_pkg::F3_JALR,
			5'd7, rv_isa_pkg::OP_JALR); // odd target drops bit 0
		for (int i = RAND_START; i < PROG_WORDS - 1; i++) begin
			rw = rv_core_pkg::word_t'($random(seed));
			rd = rand_reg(30);
			rs1 = rand_reg(32);
			rs2 = rand_reg(32);
			tgt = i + 1 + rand_below(8); // jumps only go forward
			if (tgt > PROG_WORDS - 1) begin
				tgt = PROG_WORDS - 1;
			end
			pick = rand_below(13);
			case (pick)
				0: prog[i] = enc_u(rw[31:12], rd, rv_isa_pkg::OP_LUI);
				1: prog[i] = enc_u(rw[31:12], rd, rv_isa_pkg::OP_AUIPC);
				2: prog[i] = enc_i(rw[11:0], rs1, rv_isa_pkg::F3_ADD, rd, rv_isa_pkg::OP_IMM);
				3: prog[i] = enc_r(rv_isa_pkg::F7_ADD, rs2, rs1, rd);
				4: prog[i] = enc_i(12'(4 * rand_below(16)), MEM_REG, rv_isa_pkg::F3_LW, rd,
					rv_isa_pkg::OP_LOAD);
				5: prog[i] = enc_s(12'(rand_below(64)), rs2, MEM_REG, rv_isa_pkg::F3_SB);
				6: prog[i] = enc_s(12'(2 * rand_below(32)), rs2, MEM_REG, rv_isa_pkg::F3_SH);
				7: prog[i] = enc_s(12'(4 * rand_below(16)), rs2, MEM_REG, rv_isa_pkg::F3_SW);
				8: prog[i] = enc_j(21'((tgt - i) * 4), rd);
				9: prog[i] = enc_i(12'(tgt * 4 - JUMP_BASE + (rw[0] ? 1 : 0)), JUMP_REG,
					rv_isa_pkg::F3_JALR, rd, rv_isa_pkg::OP_JALR);
				10: prog[i] = {rw[31:7], 7'b1100011}; // branch
				11: prog[i] = enc_i(rw[11:0], rs1, 3'(1 + rand_below(7)), rd, rv_isa_pkg::OP_IMM);
				default: prog[i] = enc_i(rw[11:0], rs1, 3'b000, rd, rv_isa_pkg::OP_LOAD); // lb
			endcase
		end
		prog[PROG_WORDS - 1] = enc_j(21'((PREFIX_END - (PROG_WORDS - 1)) * 4), 5'd0);
	endtask

	function automatic rv_core_pkg::word_t fetch(input rv_core_pkg::word_t addr);
		if (addr < PROG_WORDS * 4) begin
			return prog[addr[9:2]];
		end
		return NOP;
	endfunction

	// steps the ISA model by one instruction and commits its state
	function automatic void model_step(input rv_core_pkg::word_t ins);
		rv_core_pkg::opcode_t op;
		rv_core_pkg::reg_idx_t rd;
		rv_core_pkg::funct3_t f3;
		rv_core_pkg::funct7_t f7;
		rv_core_pkg::word_t a;
		rv_core_pkg::word_t b;
		rv_core_pkg::word_t imm_i;
		rv_core_pkg::word_t imm_s;
		rv_core_pkg::word_t val;
		rv_core_pkg::word_t addr;
		rv_core_pkg::word_t baddr;
		rv_core_pkg::word_t next_pc;
		logic writes;
		int nbytes;
		int widx;
		int lane;
		op = ins[6:0];
		rd = ins[11:7];
		f3 = ins[14:12];
		f7 = ins[31:25];
		a = m_regs[ins[19:15]];
		b = m_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		val = '0;
		writes = 1'b0;
		nbytes = 0;
		next_pc = m_pc + 32'd4;
		case (op)
			rv_isa_pkg::OP_LUI: begin
				val = {ins[31:12], 12'h000};
				writes = 1'b1;
			end
			rv_isa_pkg::OP_AUIPC: begin
				val = m_pc + {ins[31:12], 12'h000};
				writes = 1'b1;
			end
			rv_isa_pkg::OP_JAL: begin
				val = m_pc + 32'd4;
				writes = 1'b1;
				next_pc = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			rv_isa_pkg::OP_JALR: begin
				if (f3 == rv_isa_pkg::F3_JALR) begin
					val = m_pc + 32'd4;
					writes = 1'b1;
					next_pc = (a + imm_i) & ~32'd1;
				end
			end
			rv_isa_pkg::OP_LOAD: begin
				if (f3 == rv_isa_pkg::F3_LW) begin
					widx = int'(((a + imm_i) >> 2) % `RV_DMEM_WORDS);
					val = m_mem[widx];
					writes = 1'b1;
				end
			end
			rv_isa_pkg::OP_STORE: begin
				if (f3 == rv_isa_pkg::F3_SB) nbytes = 1;
				else if (f3 == rv_isa_pkg::F3_SH) nbytes = 2;
				else if (f3 == rv_isa_pkg::F3_SW) nbytes = 4;
			end
			rv_isa_pkg::OP_IMM: begin
				val = a + imm_i;
				writes = (f3 == rv_isa_pkg::F3_ADD);
			end
			rv_isa_pkg::OP_REG: begin
				val = a + b;
				writes = (f3 == rv_isa_pkg::F3_ADD) && (f7 == rv_isa_pkg::F7_ADD);
			end
			default: writes = 1'b0;
		endcase
		addr = a + imm_s;
		exp_mem_wen = (nbytes != 0);
		exp_mem_addr = addr;
		exp_mem_wdata = b;
		exp_mem_wmask = rv_core_pkg::byte_mask_t'((1 << nbytes) - 1);
		// little endian byte by byte
		for (int k = 0; k < nbytes; k++) begin
			baddr = addr + k;
			widx = int'((baddr >> 2) % `RV_DMEM_WORDS);
			lane = int'(baddr[1:0]);
			m_mem[widx][8*lane +: 8] = b[8*k +: 8];
		end
		exp_wb_en = writes && (rd != '0);
		exp_rd = rd;
		exp_wb_data = val;
		if (exp_wb_en) begin
			m_regs[rd] = val;
		end
		m_pc = next_pc;
	endfunction

	task automatic check_word(input string name, input rv_core_pkg::word_t got,
			input rv_core_pkg::word_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_idx(input string name, input rv_core_pkg::reg_idx_t got,
			input rv_core_pkg::reg_idx_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%0d exp=%0d", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_mask(input string name, input rv_core_pkg::byte_mask_t got,
			input rv_core_pkg::byte_mask_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	always @(posedge clk) begin
		#1;
		instr = fetch(instr_addr);
	end

	// mid-cycle compare after outputs settle
	always @(negedge clk) begin
		if (!rst_n) begin
			check_bit("wb_en", wb_en, 1'b0);
			check_bit("mem_wen", mem_wen, 1'b0);
		end else begin
			check_word("instr_addr", instr_addr, m_pc);
			model_step(instr);
			check_bit("wb_en", wb_en, exp_wb_en);
			if (exp_wb_en) begin
				check_idx("wb_rd", wb_rd, exp_rd);
				check_word("wb_data", wb_data, exp_wb_data);
			end
			check_bit("mem_wen", mem_wen, exp_mem_wen);
			if (exp_mem_wen) begin
				check_word("mem_addr", mem_addr, exp_mem_addr);
				check_word("mem_wdata", mem_wdata, exp_mem_wdata);
				check_mask("mem_wmask", mem_wmask, exp_mem_wmask);
			end
			retired++;
		end
	end

	initial begin
		int waited;
		seed = 32'hf754e1de;
		m_pc = `RV_RESET_PC;
		for (int r = 0; r < `RV_NREGS; r++) begin
			m_regs[r] = '0;
		end
		for (int w = 0; w < `RV_DMEM_WORDS; w++) begin
			m_mem[w] = '0;
		end
		build_program();
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		waited = 0;
		while (retired < RUN_CYCLES && waited < TIMEOUT_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		if (retired >= RUN_CYCLES) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("timeout: %0d of %0d instructions retired", retired, RUN_CYCLES);
			$display("Test failed");
			$fatal(1, "run did not finish");
		end
	end

endmodule
